// File: Makefile
# Verilator flow for the fetch front end
VERILATOR  ?= verilator
FILELIST   ?= fetch_front_end.f
TB_TOP     ?= fetch_front_end_tb
RTL_TOP    ?= fetch_front_end
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= Test completed successfully
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(shell grep '^logic/' $(FILELIST))
SIM_BIN  := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/fetch_front_end_properties.sv
/*
  Interface checks bound into the fetch front end top.
  All checks are idle while reset is asserted.
*/
`timescale 1ns/100ps
`default_nettype none

module fetch_front_end_properties
    import fe_instr_pkg::*;
(
    input logic           clk_i,
    input logic           rst_n_i,
    input logic           mem_stall_i,
    input logic           fetch_i,
    input logic           buf_full_i,
    input logic           stall_i,
    input logic           flush_i,
    input aligned_instr_t instr_i,
    input logic           valid_i
);

    int fail_count = 0;

    // Memory takes no request while it stalls
    no_fetch_in_mem_stall: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) mem_stall_i |-> !fetch_i
    ) else begin
        fail_count++;
        $error("fetch issued while memory was stalled");
    end

    no_fetch_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) buf_full_i |-> !fetch_i
    ) else begin
        fail_count++;
        $error("fetch issued while the instruction buffer was full");
    end

    // A flush in the same cycle may still drop the held instruction
    output_holds_on_stall: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (stall_i && !flush_i) |=> ($stable(valid_i) && (!valid_i || $stable(instr_i)))
    ) else begin
        fail_count++;
        $error("instruction output changed under back-pressure");
    end

endmodule : fetch_front_end_properties

bind fetch_front_end fetch_front_end_properties u_props (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_stall_i (mem_stall_i),
    .fetch_i     (fetch_o),
    .buf_full_i  (buf_full),
    .stall_i     (stall_i),
    .flush_i     (flush_redir.valid),
    .instr_i     (instr_o),
    .valid_i     (valid_o)
);

`default_nettype wire

// File: bench/fetch_front_end_tb.sv
/*
  Testbench for the fetch front end. Memory answers in order after a random
  latency from an LCG-built halfword image that repeats every 8 KB.
  The instruction stream is checked against a reference walk of that image.
*/
`timescale 1ns/100ps
`default_nettype none

module fetch_front_end_tb
    import fe_config_pkg::*, fe_instr_pkg::*;
();

    localparam addr_t RESET_PC     = 32'h0000_0100;
    localparam int    IBUF_DEPTH   = 4;
    localparam int    PERIOD_NS    = 8;
    localparam int    RESET_CYCLES = 16;
    localparam int    SEED         = 80881;
    localparam int    IMG_HALVES   = 4096;
    localparam int    N_PLAIN      = 200;
    localparam int    N_BRANCH     = 300;
    localparam int    N_EXC        = 50;
    localparam int    TOTAL_INSTRS = 3 * N_PLAIN + N_BRANCH + N_EXC;
    localparam int    MAX_LAT      = 4;
    localparam int    MARGIN       = 10;
    localparam int    TIMEOUT_NS   =
        (RESET_CYCLES + TOTAL_INSTRS * MAX_LAT * MARGIN) * PERIOD_NS;

    logic           clk_i;
    logic           rst_n_i;
    logic           mem_stall_i     = 1'b0;
    fetch_rsp_t     mem_rsp_i       = '0;
    logic           exception_i     = 1'b0;
    addr_t          handler_pc_i    = '0;
    logic           branch_taken_i  = 1'b0;
    addr_t          branch_target_i = '0;
    logic           stall_i         = 1'b0;
    logic           fetch_o;
    addr_t          fetch_addr_o;
    aligned_instr_t instr_o;
    logic           valid_o;

    logic [15:0] image [IMG_HALVES];

    // Knobs written only by the sequencer
    int stall_pct     = 0;
    int mem_stall_pct = 0;
    int max_lat       = 1;
    int redir_pct     = 0;
    int dual_req_cnt  = 0;

    int          dual_ack_cnt = 0;
    int          n_redirects  = 0;
    logic [31:0] stim_rng     = 32'(SEED + 2);

    // Memory model state
    addr_t       req_addr_q[$];
    int          req_due_q[$];
    int          cycle_cnt        = 0;
    int          last_due         = 0;
    logic        first_fetch_seen = 1'b0;
    int          fetch_errors     = 0;
    logic [31:0] mem_rng          = 32'(SEED + 1);

    // Comparator state
    addr_t seg_start = RESET_PC;
    int    seg_idx   = 0;
    int    n_checks  = 0;
    int    n_errors  = 0;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
        .clk_o   (clk_i),
        .rst_n_o (rst_n_i)
    );

    fetch_front_end #(.RESET_PC(RESET_PC), .IBUF_DEPTH(IBUF_DEPTH)) i_fetch_front_end (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .mem_stall_i     (mem_stall_i),
        .mem_rsp_i       (mem_rsp_i),
        .exception_i     (exception_i),
        .handler_pc_i    (handler_pc_i),
        .branch_taken_i  (branch_taken_i),
        .branch_target_i (branch_target_i),
        .stall_i         (stall_i),
        .fetch_o         (fetch_o),
        .fetch_addr_o    (fetch_addr_o),
        .instr_o         (instr_o),
        .valid_o         (valid_o)
    );

    // ==============================
    // Helpers and reference model
    // ==============================

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic below_percent(input logic [31:0] s, input int pct);
        return (int'(s[30:16]) % 100) < pct;
    endfunction

    function automatic logic [15:0] image_half(input addr_t addr);
        return image[addr[12:1]];
    endfunction

    function automatic logic [31:0] image_word(input addr_t addr);
        return {image_half(addr + 32'd2), image_half(addr)};
    endfunction

    // Stream checks, memory-side checks and bound interface checks together
    function automatic int error_total();
        return n_errors + fetch_errors + i_fetch_front_end.u_props.fail_count;
    endfunction

    // Walks count instructions from start and returns the one found there
    function automatic aligned_instr_t ref_instr(input addr_t start, input int count);
        aligned_instr_t r;
        addr_t          pc;
        logic [15:0]    low;
        pc = start;
        for (int i = 0; i < count; i++) begin
            low = image_half(pc);
            pc  = pc + ((low[1:0] == 2'b11) ? 32'd4 : 32'd2);
        end
        low  = image_half(pc);
        r.pc = pc;
        if (low[1:0] == 2'b11) begin
            r.instr      = {image_half(pc + 32'd2), low};
            r.compressed = 1'b0;
        end else begin
            r.instr      = {16'h0000, low};
            r.compressed = 1'b1;
        end
        return r;
    endfunction

    // Roughly half the halfwords open a 32-bit instruction
    initial begin
        logic [31:0] rng;
        rng = 32'(SEED);
        for (int i = 0; i < IMG_HALVES; i++) begin
            rng      = lcg_step(rng);
            image[i] = rng[31:16];
            rng      = lcg_step(rng);
            if (rng[31]) begin
                image[i][1:0] = 2'b11;
            end else if (image[i][1:0] == 2'b11) begin
                image[i][1:0] = 2'b01;
            end
        end
    end

    // ==============================
    // Memory model
    // ==============================

    always @(negedge clk_i) begin
        int lat;
        int due;
        cycle_cnt   = cycle_cnt + 1;
        mem_rng     = lcg_step(mem_rng);
        mem_stall_i = rst_n_i && below_percent(mem_rng, mem_stall_pct);
        mem_rsp_i   = '0;
        if (req_due_q.size() != 0 && req_due_q[0] <= cycle_cnt) begin
            mem_rsp_i.valid     = 1'b1;
            mem_rsp_i.data.word = image_word(req_addr_q[0]);
            void'(req_addr_q.pop_front());
            void'(req_due_q.pop_front());
        end
        // Requests are taken once the inputs of this cycle have settled
        #2;
        if (rst_n_i && fetch_o) begin
            assert (fetch_addr_o[1:0] == 2'b00) else begin
                fetch_errors++;
                $display("mismatch at %0t: fetch address %h not word aligned",
                         $time, fetch_addr_o);
            end
            if (!first_fetch_seen) begin
                first_fetch_seen = 1'b1;
                assert (fetch_addr_o == RESET_PC) else begin
                    fetch_errors++;
                    $display("mismatch at %0t: first fetch address %h, expected %h",
                             $time, fetch_addr_o, RESET_PC);
                end
            end
            mem_rng = lcg_step(mem_rng);
            lat     = 1 + int'(mem_rng[30:16]) % max_lat;
            due     = cycle_cnt + lat;
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            req_addr_q.push_back(fetch_addr_o);
            req_due_q.push_back(due);
        end
    end

    // ==============================
    // Back-end stimulus
    // ==============================

    always @(negedge clk_i) begin
        stim_rng       = lcg_step(stim_rng);
        stall_i        = rst_n_i && below_percent(stim_rng, stall_pct);
        exception_i    = 1'b0;
        branch_taken_i = 1'b0;
        if (rst_n_i && dual_ack_cnt != dual_req_cnt) begin
            // Both redirects at once with different targets
            stim_rng        = lcg_step(stim_rng);
            exception_i     = 1'b1;
            handler_pc_i    = stim_rng & 32'h0000_1FFE;
            branch_taken_i  = 1'b1;
            branch_target_i = handler_pc_i ^ 32'h0000_0802;
            dual_ack_cnt++;
            n_redirects++;
        end else if (rst_n_i) begin
            stim_rng = lcg_step(stim_rng);
            if (below_percent(stim_rng, redir_pct)) begin
                stim_rng        = lcg_step(stim_rng);
                branch_taken_i  = 1'b1;
                branch_target_i = stim_rng & 32'h0000_1FFE;
                n_redirects++;
            end
        end
    end

    // ==============================
    // Comparator
    // ==============================

    always @(negedge clk_i) begin
        aligned_instr_t expected;
        #2;
        if (!rst_n_i) begin
            assert (!fetch_o && !valid_o) else begin
                n_errors++;
                $display("mismatch at %0t: fetch_o or valid_o high while reset was asserted",
                         $time);
            end
        end else if (exception_i || branch_taken_i) begin
            // A redirect flushes the held output and the exception target wins
            seg_start = exception_i ? handler_pc_i : branch_target_i;
            seg_idx   = 0;
        end else if (valid_o && !stall_i) begin
            expected = ref_instr(seg_start, seg_idx);
            n_checks++;
            assert (instr_o == expected) else begin
                n_errors++;
                $display("mismatch at %0t: got pc %h instr %h c=%b, expected pc %h instr %h c=%b",
                         $time, instr_o.pc, instr_o.instr, instr_o.compressed,
                         expected.pc, expected.instr, expected.compressed);
            end
            seg_idx++;
        end
    end

    // ==============================
    // Sequencer and watchdog
    // ==============================

    task automatic run_phase(input int num, input string name, input int s_pct,
                             input int m_pct, input int lat, input int r_pct,
                             input bit dual, input int count);
        int err_base;
        int chk_base;
        err_base      = error_total();
        chk_base      = n_checks;
        stall_pct     = s_pct;
        mem_stall_pct = m_pct;
        max_lat       = lat;
        redir_pct     = r_pct;
        if (dual) begin
            dual_req_cnt++;
            while (dual_ack_cnt != dual_req_cnt) @(posedge clk_i);
        end
        while (n_checks < chk_base + count) @(posedge clk_i);
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 n_checks - chk_base, error_total() - err_base);
    endtask

    initial begin
        @(posedge rst_n_i);
        while (!first_fetch_seen) @(posedge clk_i);
        $display("test 1 reset_and_first_fetch: %0d errors", error_total());
        run_phase(2, "no_stall", 0, 0, 1, 0, 1'b0, N_PLAIN);
        run_phase(3, "back_pressure", 30, 0, 1, 0, 1'b0, N_PLAIN);
        run_phase(4, "memory_stall", 0, 30, MAX_LAT, 0, 1'b0, N_PLAIN);
        run_phase(5, "branch_redirect", 25, 25, MAX_LAT, 3, 1'b0, N_BRANCH);
        run_phase(6, "exception_wins", 0, 20, MAX_LAT, 0, 1'b1, N_EXC);
        $display("6 tests, %0d checks, %0d redirects, %0d errors",
                 n_checks, n_redirects, error_total());
        if (error_total() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns, %0d of %0d checks done",
                 TIMEOUT_NS, n_checks, TOTAL_INSTRS);
        $display("Test failed");
        $finish;
    end

endmodule : fetch_front_end_tb

`default_nettype wire

// File: bench/tb_clock_gen.sv
/*
  Testbench clock and synchronous reset. Reset is held low over the first
  RESET_CYCLES rising edges and released on a falling edge.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

// File: fetch_front_end.f
logic/fe_config_pkg.sv
logic/fe_instr_pkg.sv
logic/pc_generator.sv
logic/fetch_buffer.sv
logic/instr_aligner.sv
logic/fetch_front_end.sv
bench/tb_clock_gen.sv
bench/fetch_front_end_properties.sv
bench/fetch_front_end_tb.sv

// File: logic/fe_config_pkg.sv
/*
  Widths and constants shared by the fetch front end.
  Addresses and memory words are both 32 bits wide.
*/
`default_nettype none

package fe_config_pkg;

    // Byte address as seen by instruction memory
    localparam int ADDR_W = 32;
    typedef logic [ADDR_W-1:0] addr_t;

    // One memory word holds two halfwords
    localparam int WORD_W = 32;
    localparam int HALF_W = 16;

    // Low two bits of a halfword that open a 32-bit instruction
    localparam logic [1:0] FULL_OPCODE_LOW = 2'b11;

    // Default reset vector, expected to be word aligned
    localparam addr_t DEFAULT_RESET_PC = 32'h0000_0000;

endpackage : fe_config_pkg

`default_nettype wire

// File: logic/fe_instr_pkg.sv
/*
  Payload types that travel between memory, the instruction buffer and the aligner.
  Halfword 0 of a fetched word is the lower address.
*/
`default_nettype none

package fe_instr_pkg;

    import fe_config_pkg::*;

    // A fetched word is read whole or as two halfwords
    typedef union packed {
        logic [WORD_W-1:0]         word;
        logic [1:0][HALF_W-1:0]    half;
    } fetch_word_u;

    typedef struct packed {
        logic        valid;
        fetch_word_u data;
    } fetch_rsp_t;

    typedef struct packed {
        fetch_word_u data;
        addr_t       addr;
    } ibuf_entry_t;

    // Compressed instructions sit zero extended in the low half
    typedef struct packed {
        logic [WORD_W-1:0] instr;
        addr_t             pc;
        logic              compressed;
    } aligned_instr_t;

    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

endpackage : fe_instr_pkg

`default_nettype wire

// File: logic/fetch_buffer.sv
/*
  Instruction word FIFO. IBUF_DEPTH must be a power of two, at least 2.
  Memory must answer every request once and in order. Pop is trusted to come
  only while the buffer is non-empty.
*/
`timescale 1ns/100ps
`default_nettype none

module fetch_buffer
    import fe_config_pkg::*, fe_instr_pkg::*;
#(
    parameter int IBUF_DEPTH = 8
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        fetch_i,
    input  addr_t       fetch_addr_i,
    input  fetch_rsp_t  mem_rsp_i,
    input  logic        flush_i,
    input  logic        pop_i,
    output ibuf_entry_t entry_o,
    output logic        nonempty_o,
    output logic        full_o
);

    localparam int PTR_W = $clog2(IBUF_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // Address column is written at request time, word column at response time
    addr_t       addr_mem [IBUF_DEPTH];
    fetch_word_u word_mem [IBUF_DEPTH];

    logic [PTR_W-1:0] req_ptr, rsp_ptr, rd_ptr;
    logic [CNT_W-1:0] n_stored, n_reserved, discard_q, occupancy;
    logic             accept, drop;

    // Responses still owed to requests from before a flush are dropped
    assign drop   = mem_rsp_i.valid & (discard_q != '0);
    assign accept = mem_rsp_i.valid & (discard_q == '0) & !flush_i;

    // Stale responses still occupy memory, so they count against the depth
    assign occupancy  = n_stored + n_reserved + discard_q;
    assign full_o     = (occupancy == CNT_W'(IBUF_DEPTH));
    assign nonempty_o = (n_stored != '0);

    assign entry_o.data = word_mem[rd_ptr];
    assign entry_o.addr = addr_mem[rd_ptr];

    // ==============================
    // Bookkeeping
    // ==============================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            req_ptr    <= '0;
            rsp_ptr    <= '0;
            rd_ptr     <= '0;
            n_stored   <= '0;
            n_reserved <= '0;
            discard_q  <= '0;
        end else if (flush_i) begin
            req_ptr    <= '0;
            rsp_ptr    <= '0;
            rd_ptr     <= '0;
            n_stored   <= '0;
            n_reserved <= '0;
            // Every response still out is stale, minus the one landing now
            discard_q  <= discard_q + n_reserved - CNT_W'(mem_rsp_i.valid);
        end else begin
            if (fetch_i) begin
                req_ptr <= req_ptr + 1'b1;
            end
            if (accept) begin
                rsp_ptr <= rsp_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (drop) begin
                discard_q <= discard_q - 1'b1;
            end
            n_stored   <= n_stored + CNT_W'(accept) - CNT_W'(pop_i);
            n_reserved <= n_reserved + CNT_W'(fetch_i) - CNT_W'(accept);
        end
    end

    // ==============================
    // Storage
    // ==============================

    always_ff @(posedge clk_i) begin
        if (fetch_i) begin
            addr_mem[req_ptr] <= fetch_addr_i;
        end
        if (accept) begin
            word_mem[rsp_ptr] <= mem_rsp_i.data;
        end
    end

endmodule : fetch_buffer

`default_nettype wire

// File: logic/fetch_front_end.sv
/*
  Fetch front end top. RESET_PC should be word aligned.
  Up to IBUF_DEPTH requests may be outstanding at memory.
*/
`timescale 1ns/100ps
`default_nettype none

module fetch_front_end
    import fe_config_pkg::*, fe_instr_pkg::*;
#(
    parameter addr_t RESET_PC   = DEFAULT_RESET_PC,
    parameter int    IBUF_DEPTH = 8
) (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           mem_stall_i,
    input  fetch_rsp_t     mem_rsp_i,
    input  logic           exception_i,
    input  addr_t          handler_pc_i,
    input  logic           branch_taken_i,
    input  addr_t          branch_target_i,
    input  logic           stall_i,
    output logic           fetch_o,
    output addr_t          fetch_addr_o,
    output aligned_instr_t instr_o,
    output logic           valid_o
);

    redirect_t   flush_redir;
    ibuf_entry_t ibuf_entry;
    logic        buf_full, ibuf_nonempty, pop;

    pc_generator #(.RESET_PC(RESET_PC)) u_pc_gen (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .exception_i     (exception_i),
        .handler_pc_i    (handler_pc_i),
        .branch_taken_i  (branch_taken_i),
        .branch_target_i (branch_target_i),
        .mem_stall_i     (mem_stall_i),
        .buf_full_i      (buf_full),
        .fetch_o         (fetch_o),
        .fetch_addr_o    (fetch_addr_o),
        .flush_redir_o   (flush_redir)
    );

    fetch_buffer #(.IBUF_DEPTH(IBUF_DEPTH)) u_fetch_buf (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fetch_i      (fetch_o),
        .fetch_addr_i (fetch_addr_o),
        .mem_rsp_i    (mem_rsp_i),
        .flush_i      (flush_redir.valid),
        .pop_i        (pop),
        .entry_o      (ibuf_entry),
        .nonempty_o   (ibuf_nonempty),
        .full_o       (buf_full)
    );

    instr_aligner u_aligner (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .entry_i    (ibuf_entry),
        .nonempty_i (ibuf_nonempty),
        .flush_i    (flush_redir),
        .stall_i    (stall_i),
        .pop_o      (pop),
        .instr_o    (instr_o),
        .valid_o    (valid_o)
    );

endmodule : fetch_front_end

`default_nettype wire

// File: logic/instr_aligner.sv
/*
  Splits buffered words into 16-bit and 32-bit instructions. Compressed ones are
  not expanded. A 32-bit instruction crossing a word boundary costs one bubble.
*/
`timescale 1ns/100ps
`default_nettype none

module instr_aligner
    import fe_config_pkg::*, fe_instr_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  ibuf_entry_t    entry_i,
    input  logic           nonempty_i,
    input  redirect_t      flush_i,
    input  logic           stall_i,
    output logic           pop_o,
    output aligned_instr_t instr_o,
    output logic           valid_o
);

    fetch_word_u       cur;
    aligned_instr_t    next_instr, out_q;
    addr_t             upper_pc, saved_pc_q;
    logic [HALF_W-1:0] saved_half_q;
    logic              upper_q, upper_d, saved_q, valid_q;
    logic              advance, emit, pop, save;

    assign cur      = entry_i.data;
    assign upper_pc = entry_i.addr + addr_t'(2);
    assign advance  = nonempty_i & !stall_i & !flush_i.valid;

    // ==============================
    // Halfword selection
    // ==============================

    always_comb begin
        emit       = 1'b0;
        pop        = 1'b0;
        save       = 1'b0;
        upper_d    = upper_q;
        next_instr = '{instr: cur.word, pc: entry_i.addr, compressed: 1'b0};
        if (saved_q) begin
            // Saved upper half is the low part, this word's low half completes it
            next_instr.instr = {cur.half[0], saved_half_q};
            next_instr.pc    = saved_pc_q;
            emit             = 1'b1;
            upper_d          = 1'b1;
        end else if (!upper_q) begin
            emit = 1'b1;
            if (cur.half[0][1:0] == FULL_OPCODE_LOW) begin
                pop = 1'b1;
            end else begin
                next_instr.instr      = {{HALF_W{1'b0}}, cur.half[0]};
                next_instr.compressed = 1'b1;
                upper_d               = 1'b1;
            end
        end else begin
            pop           = 1'b1;
            upper_d       = 1'b0;
            next_instr.pc = upper_pc;
            if (cur.half[1][1:0] == FULL_OPCODE_LOW) begin
                save = 1'b1;
            end else begin
                emit                  = 1'b1;
                next_instr.instr      = {{HALF_W{1'b0}}, cur.half[1]};
                next_instr.compressed = 1'b1;
            end
        end
    end

    assign pop_o = advance & pop;

    // ==============================
    // State and output register
    // ==============================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            upper_q <= 1'b0;
            saved_q <= 1'b0;
            valid_q <= 1'b0;
        end else if (flush_i.valid) begin
            // Restart on the half that holds the target
            upper_q <= flush_i.target[1];
            saved_q <= 1'b0;
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= advance & emit;
            if (advance) begin
                upper_q <= upper_d;
                saved_q <= save;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance & save) begin
            saved_half_q <= cur.half[1];
            saved_pc_q   <= upper_pc;
        end
        if (advance & emit) begin
            out_q <= next_instr;
        end
    end

    assign instr_o = out_q;
    assign valid_o = valid_q;

endmodule : instr_aligner

`default_nettype wire

// File: logic/pc_generator.sv
/*
  Fetch pc and request strobe. Redirect targets must be halfword aligned.
  Fetching starts one cycle after reset is released.
*/
`timescale 1ns/100ps
`default_nettype none

module pc_generator
    import fe_config_pkg::*, fe_instr_pkg::*;
#(
    parameter addr_t RESET_PC = DEFAULT_RESET_PC
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      exception_i,
    input  addr_t     handler_pc_i,
    input  logic      branch_taken_i,
    input  addr_t     branch_target_i,
    input  logic      mem_stall_i,
    input  logic      buf_full_i,
    output logic      fetch_o,
    output addr_t     fetch_addr_o,
    output redirect_t flush_redir_o
);

    addr_t     pc_q;
    logic      run_q;
    redirect_t redir;

    // Exception or interrupt outranks a resolved branch
    always_comb begin
        redir.valid  = exception_i | branch_taken_i;
        redir.target = branch_target_i;
        if (exception_i) begin
            redir.target = handler_pc_i;
        end
    end

    // A redirect cycle never issues, the target word goes out from the next cycle
    assign fetch_o       = run_q & !redir.valid & !mem_stall_i & !buf_full_i;
    assign fetch_addr_o  = pc_q;
    assign flush_redir_o = redir;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            run_q <= 1'b0;
            pc_q  <= {RESET_PC[ADDR_W-1:2], 2'b00};
        end else begin
            run_q <= 1'b1;
            if (redir.valid) begin
                pc_q <= {redir.target[ADDR_W-1:2], 2'b00};
            end else if (fetch_o) begin
                pc_q <= pc_q + addr_t'(4);
            end
        end
    end

endmodule : pc_generator

`default_nettype wire
